// ==== bench/dma_ctrl_tb.sv ====
//******************************
// Random AXI traffic on 16 dwords plus
// out-of-window and misaligned cases
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_tb;
   import dma_pkg::*;

   localparam int    DEPTH  = 4;
   localparam int    ID_W   = 4;
   localparam int    TAG_W  = $clog2(DEPTH);
   localparam addr_t BASE   = 32'hf004_0000;
   localparam addr_t SIZE   = 32'h0001_0000;
   localparam int    N_CMDS = 200;
   localparam int    LIMIT  = N_CMDS * 40;
   localparam int    T      = 3;          // Stall threshold for the directed test

   logic clk, reset, dccm_hold;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [ID_W-1:0] awid, bid, arid, rid;
   addr_t awaddr, araddr, mem_addr;
   logic [2:0] awsize, arsize, qos_thresh;
   data_t wdata, rdata, mem_wdata, dccm_rdata;
   strb_t wstrb;
   resp_e bresp, rresp;
   logic dccm_req, dccm_ready, mem_write, dccm_rvalid, dccm_ecc_error, dccm_stall;
   logic [TAG_W-1:0] mem_tag, dccm_rtag;
   size_e mem_size;

   integer seed, errors, checks, cycles, outstanding, issued, k;
   logic aw_fire, w_fire, ar_fire, ok, e_ecc;
   logic [ID_W-1:0] id_ctr, e_id;
   resp_e e_code;
   data_t e_data;
   addr_t rd_addr;                      // Address of the next random read
   logic [31:0] r;
   data_t shadow [16];                  // Reference copy of the dword pool

   // Expected responses per channel, oldest first
   logic [ID_W-1:0] wq_id [$], rq_id [$];
   resp_e wq_code [$], rq_code [$];
   logic [28:0] wq_dw [$], rq_dw [$];
   data_t rq_data [$];
   addr_t mw_addr [$], mr_addr [$];     // Expected memory port traffic
   size_e mw_size [$], mr_size [$];
   logic ecc_q [$];

   dma_ctrl_top #(.DEPTH(DEPTH), .ID_W(ID_W), .DCCM_BASE(BASE), .DCCM_SIZE(SIZE))
      u_dma_ctrl_top (.*);
   dma_mem_model #(.TAG_W(TAG_W), .BASE(BASE)) u_mem_model (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   function automatic data_t fill(input addr_t a);
      return {a ^ 32'h5a5a_5a5a, a};
   endfunction

   // Response code from the DCCM window and the size and strobe rules
   function automatic resp_e expect_code(input addr_t a, input logic [2:0] sz,
                                         input strb_t s, input logic wr);
      logic mis, bad;
      if (a < BASE || a >= BASE + SIZE)
         return resp_decerr;
      mis = (sz == 3'd1 && a[0]) || (sz == 3'd2 && a[1:0] != 2'd0) ||
            (sz == 3'd3 && a[2:0] != 3'd0);
      bad = wr && (sz < 3'd2 ||
            (sz == 3'd2 && (a[2] ? s[7:4] != 4'hf : s[3:0] != 4'hf)) ||
            (sz == 3'd3 && !(s inside {8'h0f, 8'hf0, 8'hff})));
      return (mis || bad) ? resp_slverr : resp_okay;
   endfunction

   // Same dword in flight with a write on either side
   function automatic logic conflict(input addr_t a, input logic wr);
      foreach (wq_dw[i])
         if (wq_dw[i] == a[31:3])
            return 1'b1;
      if (wr)
         foreach (rq_dw[i])
            if (rq_dw[i] == a[31:3])
               return 1'b1;
      return 1'b0;
   endfunction

   task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_true(input string what, input logic cond);
      checks++;
      assert (cond) else begin
         errors++;
         $display("Error at %0t: %s", $time, what);
      end
   endtask

   task automatic pick_addr(input logic [2:0] sz, output addr_t a);
      logic [31:0] rr;
      rr = $random(seed);
      if (rr[2:0] == 3'd0)
         a = BASE + SIZE + 32'({rr[10:7], 3'b000});              // Outside the window
      else if (rr[2:0] == 3'd1)
         a = BASE + 32'({rr[10:7], rr[13:11]});                  // Any byte offset
      else
         a = BASE + 32'({rr[10:7], rr[13:11] & (3'b111 << sz)});
   endtask

   task automatic issue_write(output logic done);
      addr_t a;
      logic [2:0] sz;
      strb_t s;
      data_t d;
      resp_e c;
      logic [31:0] rr;
      rr = $random(seed);
      sz = (rr[2:0] == 3'd0) ? {1'b0, rr[4:3]} : {2'b01, rr[5]};
      case (rr[7:6])
         2'd0: s = 8'hff;
         2'd1: s = 8'h0f;
         2'd2: s = 8'hf0;
         default: s = rr[15:8];
      endcase
      d = {32'($random(seed)), 32'($random(seed))};
      pick_addr(sz, a);
      done = ~conflict(a, 1'b1);
      if (done) begin
         c = expect_code(a, sz, s, 1'b1);
         awvalid <= 1'b1;
         awid    <= id_ctr;
         awaddr  <= a;
         awsize  <= sz;
         wvalid  <= 1'b1;
         wdata   <= d;
         wstrb   <= s;
         wq_id.push_back(id_ctr);
         wq_code.push_back(c);
         wq_dw.push_back(a[31:3]);
         if (c == resp_okay) begin
            if (sz == 3'd2 && a[2])
               shadow[a[6:3]][63:32] = d[63:32];
            else if (sz == 3'd2)
               shadow[a[6:3]][31:0] = d[31:0];
            else
               for (int b = 0; b < 8; b++)
                  if (s[b])
                     shadow[a[6:3]][8*b +: 8] = d[8*b +: 8];
            // Half-dword writes reach the memory as words
            mw_addr.push_back((sz == 3'd3 && s == 8'hf0) ? (a | 32'd4) : a);
            mw_size.push_back((sz == 3'd3 && s != 8'hff) ? sz_word : size_e'(sz));
         end
         id_ctr++;
      end
   endtask

   task automatic issue_read(input addr_t a, input logic [2:0] sz, output logic done);
      resp_e c;
      done = ~conflict(a, 1'b0);
      if (done) begin
         c = expect_code(a, sz, 8'h00, 1'b0);
         arvalid <= 1'b1;
         arid    <= id_ctr;
         araddr  <= a;
         arsize  <= sz;
         rq_id.push_back(id_ctr);
         rq_code.push_back(c);
         rq_dw.push_back(a[31:3]);
         rq_data.push_back((c == resp_okay) ? shadow[a[6:3]] : {32'b0, a});
         if (c == resp_okay) begin
            mr_addr.push_back(a);
            mr_size.push_back(size_e'(sz));
         end
         id_ctr++;
      end
   endtask

   //******************************
   // Monitor, outputs are stable at the falling edge
   //******************************
   always @(negedge clk) begin
      aw_fire = ~reset & awvalid & awready;
      w_fire  = ~reset & wvalid & wready;
      ar_fire = ~reset & arvalid & arready;
      if (!reset) begin
         outstanding = outstanding + int'(aw_fire) + int'(ar_fire);
         if (dccm_rvalid)
            ecc_q.push_back(dccm_ecc_error);
         if (dccm_req) begin
            check_true("memory request outside the DCCM window", (mem_addr - BASE) < SIZE);
            if (mem_write && mw_addr.size() > 0) begin
               check_eq("write mem_addr", mem_addr, mw_addr.pop_front());
               check_eq("write mem_size", mem_size, mw_size.pop_front());
            end else if (!mem_write && mr_addr.size() > 0) begin
               check_eq("read mem_addr", mem_addr, mr_addr.pop_front());
               check_eq("read mem_size", mem_size, mr_size.pop_front());
            end else begin
               check_true("memory request with no valid command waiting", 1'b0);
            end
         end
         if (bvalid && bready) begin
            outstanding--;
            if (wq_id.size() == 0) begin
               check_true("write response with no write outstanding", 1'b0);
            end else begin
               void'(wq_dw.pop_front());
               check_eq("bid", bid, wq_id.pop_front());
               check_eq("bresp", bresp, wq_code.pop_front());
            end
         end
         if (rvalid && rready) begin
            outstanding--;
            if (rq_id.size() == 0) begin
               check_true("read response with no read outstanding", 1'b0);
            end else begin
               void'(rq_dw.pop_front());
               e_id   = rq_id.pop_front();
               e_code = rq_code.pop_front();
               e_data = rq_data.pop_front();
               e_ecc  = 1'b0;
               check_eq("rid", rid, e_id);
               if (e_code == resp_okay && ecc_q.size() == 0)
                  check_true("read response before the memory returned data", 1'b0);
               else if (e_code == resp_okay)
                  e_ecc = ecc_q.pop_front();
               check_eq("rresp", rresp, e_ecc ? resp_slverr : e_code);
               if (!e_ecc)
                  check_eq("rdata", rdata, e_data);
            end
         end
         // Buffer entries plus one held write and one held read
         check_true("more commands outstanding than the DUT can hold",
                    outstanding <= DEPTH + 2);
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", LIMIT);
         $display("test failed");
         $finish;
      end
   end

   //******************************
   // Stimulus
   //******************************
   initial begin
      seed = 32'h04ea504a;
      errors = 0;
      checks = 0;
      cycles = 0;
      outstanding = 0;
      issued = 0;
      id_ctr = '0;
      for (int i = 0; i < 16; i++)
         shadow[i] = fill(BASE + 32'(i * 8));
      reset = 1'b1;
      dccm_hold = 1'b0;
      qos_thresh = 3'd7;
      awvalid = 1'b0;
      awid = '0;
      awaddr = '0;
      awsize = '0;
      wvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      bready = 1'b0;
      arvalid = 1'b0;
      arid = '0;
      araddr = '0;
      arsize = '0;
      rready = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      while (issued < N_CMDS || wq_id.size() > 0 || rq_id.size() > 0) begin
         @(posedge clk);
         r = $random(seed);
         bready <= r[0] | r[1];   // Random back-pressure
         rready <= r[2] | r[3];
         if (aw_fire)
            awvalid <= 1'b0;
         if (w_fire)
            wvalid <= 1'b0;
         if (ar_fire)
            arvalid <= 1'b0;
         if (issued < N_CMDS && (!awvalid || aw_fire) && (!wvalid || w_fire) && r[4]) begin
            issue_write(ok);
            issued = issued + int'(ok);
         end
         if (issued < N_CMDS && (!arvalid || ar_fire) && r[5]) begin
            pick_addr({1'b0, r[7:6]}, rd_addr);
            issue_read(rd_addr, {1'b0, r[7:6]}, ok);
            issued = issued + int'(ok);
         end
      end

      // Directed stall test with the memory refusing
      @(posedge clk);
      bready <= 1'b1;
      rready <= 1'b1;
      dccm_hold <= 1'b1;
      qos_thresh <= 3'(T);
      @(posedge clk);
      issue_read(BASE, 3'd3, ok);
      @(posedge clk);
      while (!ar_fire)
         @(posedge clk);
      arvalid <= 1'b0;
      k = 0;
      do begin
         @(negedge clk);
         k++;
         check_true("dccm_req while the memory is not ready", !dccm_req);
      end while (!dccm_stall);
      // One cycle to cmd_valid and one to load, then T refused cycles
      check_eq("cycles until dccm_stall", 64'(k), 64'(T + 2));
      @(posedge clk);
      dccm_hold <= 1'b0;
      do
         @(negedge clk);
      while (!dccm_req);
      @(negedge clk);
      check_eq("dccm_stall after acceptance", dccm_stall, 1'b0);
      while (rq_id.size() > 0)
         @(posedge clk);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/dma_mem_model.sv ====
//******************************
// Behavioral DCCM, 64 KB from BASE
// Reads return in request order
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_mem_model #(
   parameter int             TAG_W = 2,
   parameter dma_pkg::addr_t BASE  = 32'hf004_0000
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             dccm_hold,    // Forces ready low
   input  logic             dccm_req,
   output logic             dccm_ready,
   input  logic [TAG_W-1:0] mem_tag,
   input  dma_pkg::addr_t   mem_addr,
   input  dma_pkg::size_e   mem_size,
   input  logic             mem_write,
   input  dma_pkg::data_t   mem_wdata,
   output logic             dccm_rvalid,
   output logic [TAG_W-1:0] dccm_rtag,
   output dma_pkg::data_t   dccm_rdata,
   output logic             dccm_ecc_error
);
   import dma_pkg::*;

   data_t            mem [8192];
   logic [TAG_W-1:0] tag_q [$];
   data_t            data_q [$];
   integer           mseed;
   logic [31:0]      r;
   addr_t            offset;

   initial begin
      mseed = 32'h04ea504a;
      dccm_ready     = 1'b0;
      dccm_rvalid    = 1'b0;
      dccm_rtag      = '0;
      dccm_rdata     = '0;
      dccm_ecc_error = 1'b0;
      for (int i = 0; i < 8192; i++)
         mem[i] = {(BASE + 32'(i * 8)) ^ 32'h5a5a_5a5a, BASE + 32'(i * 8)};
   end

   always @(posedge clk) begin
      r = $random(mseed);
      offset = mem_addr - BASE;
      if (reset) begin
         dccm_ready     <= 1'b0;
         dccm_rvalid    <= 1'b0;
         dccm_rtag      <= '0;
         dccm_rdata     <= '0;
         dccm_ecc_error <= 1'b0;
         tag_q.delete();
         data_q.delete();
      end else begin
         dccm_ready  <= ~dccm_hold & (r[1:0] != 2'd0);
         dccm_rvalid <= 1'b0;
         if (dccm_req && mem_write) begin
            if (mem_size == sz_word && mem_addr[2])
               mem[offset[15:3]][63:32] = mem_wdata[63:32];
            else if (mem_size == sz_word)
               mem[offset[15:3]][31:0] = mem_wdata[31:0];
            else
               mem[offset[15:3]] = mem_wdata;
         end else if (dccm_req) begin
            tag_q.push_back(mem_tag);
            data_q.push_back(mem[offset[15:3]]);
         end
         if (tag_q.size() > 0 && r[2]) begin   // Random return delay
            dccm_rvalid    <= 1'b1;
            dccm_rtag      <= tag_q.pop_front();
            dccm_rdata     <= data_q.pop_front();
            dccm_ecc_error <= (r[5:3] == 3'd0);   // One read in eight
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dma_access_check.sv ====
//******************************
// Writes must be word or dword sized
// Window must be dword aligned
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_access_check #(
   parameter dma_pkg::addr_t DCCM_BASE = 32'hf004_0000,
   parameter dma_pkg::addr_t DCCM_SIZE = 32'h0001_0000
) (
   input  dma_pkg::addr_t head_addr,
   input  dma_pkg::size_e head_size,
   input  dma_pkg::strb_t head_strb,
   input  logic           head_write,
   output logic           range_error,
   output logic           align_error,
   output dma_pkg::addr_t mem_addr,
   output dma_pkg::size_e mem_size
);
   import dma_pkg::*;

   addr_t offset;
   logic  misaligned, narrow_write, word_strb_bad, half_dword, dword_strb_bad, narrow;

   // Unsigned wrap also catches addresses below the base
   assign offset      = head_addr - DCCM_BASE;
   assign range_error = (offset >= DCCM_SIZE);

   always_comb begin
      case (head_size)
         sz_byte:  misaligned = 1'b0;
         sz_half:  misaligned = head_addr[0];
         sz_word:  misaligned = |head_addr[1:0];
         sz_dword: misaligned = |head_addr[2:0];
         default:  misaligned = 1'b1;   // Wider than the bus
      endcase
   end

   assign narrow_write   = head_write & ((head_size == sz_byte) | (head_size == sz_half));
   assign word_strb_bad  = head_write & (head_size == sz_word) &
                           (head_addr[2] ? (head_strb[7:4] != 4'hf) : (head_strb[3:0] != 4'hf));
   assign half_dword     = (head_strb == 8'h0f) | (head_strb == 8'hf0);
   assign dword_strb_bad = head_write & (head_size == sz_dword) & ~half_dword &
                           (head_strb != 8'hff);

   // Decode errors take priority over slave errors
   assign align_error = ~range_error &
                        (misaligned | narrow_write | word_strb_bad | dword_strb_bad);

   // Half-dword writes go out as words
   assign narrow   = head_write & (head_size == sz_dword) & half_dword;
   assign mem_size = narrow ? sz_word : head_size;
   assign mem_addr = (narrow && head_strb == 8'hf0) ?
                     {head_addr[31:3], 1'b1, head_addr[1:0]} : head_addr;

endmodule

`default_nettype wire

// ==== hdl/dma_bus_ingress.sv ====
//******************************
// One write and one read held at a time
// Ties between them alternate
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_bus_ingress #(
   parameter int ID_W = 4
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            awvalid,
   output logic            awready,
   input  logic [ID_W-1:0] awid,
   input  dma_pkg::addr_t  awaddr,
   input  logic [2:0]      awsize,
   input  logic            wvalid,
   output logic            wready,
   input  dma_pkg::data_t  wdata,
   input  dma_pkg::strb_t  wstrb,
   input  logic            arvalid,
   output logic            arready,
   input  logic [ID_W-1:0] arid,
   input  dma_pkg::addr_t  araddr,
   input  logic [2:0]      arsize,
   output logic            cmd_valid,
   input  logic            cmd_ready,
   output logic            cmd_write,
   output logic [ID_W-1:0] cmd_id,
   output dma_pkg::addr_t  cmd_addr,
   output dma_pkg::size_e  cmd_size,
   output dma_pkg::data_t  cmd_wdata,
   output dma_pkg::strb_t  cmd_strb
);
   import dma_pkg::*;

   logic            aw_vld, w_vld, ar_vld;
   logic [ID_W-1:0] aw_id_q, ar_id_q;
   addr_t           aw_addr_q, ar_addr_q;
   size_e           aw_size_q, ar_size_q;
   data_t           w_data_q;
   strb_t           w_strb_q;
   logic            prio_wr;     // Write wins the next tie
   logic            wr_full;
   logic            cmd_sent, wr_sent, rd_sent;

   assign wr_full   = aw_vld & w_vld;
   assign cmd_valid = wr_full | ar_vld;
   assign cmd_write = wr_full & (~ar_vld | prio_wr);
   assign cmd_sent  = cmd_valid & cmd_ready;
   assign wr_sent   = cmd_sent & cmd_write;
   assign rd_sent   = cmd_sent & ~cmd_write;

   // A slot can refill on the edge that sends its command
   assign awready = ~aw_vld | wr_sent;
   assign wready  = ~w_vld | wr_sent;
   assign arready = ~ar_vld | rd_sent;

   always_ff @(posedge clk) begin
      if (reset) begin
         aw_vld  <= 1'b0;
         w_vld   <= 1'b0;
         ar_vld  <= 1'b0;
         prio_wr <= 1'b0;
      end else begin
         if (awvalid && awready)
            aw_vld <= 1'b1;
         else if (wr_sent)
            aw_vld <= 1'b0;
         if (wvalid && wready)
            w_vld <= 1'b1;
         else if (wr_sent)
            w_vld <= 1'b0;
         if (arvalid && arready)
            ar_vld <= 1'b1;
         else if (rd_sent)
            ar_vld <= 1'b0;
         if (cmd_sent)
            prio_wr <= ~prio_wr;
      end
   end

   // Payload holding registers
   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         aw_id_q   <= awid;
         aw_addr_q <= awaddr;
         aw_size_q <= size_e'(awsize);
      end
      if (wvalid && wready) begin
         w_data_q <= wdata;
         w_strb_q <= wstrb;
      end
      if (arvalid && arready) begin
         ar_id_q   <= arid;
         ar_addr_q <= araddr;
         ar_size_q <= size_e'(arsize);
      end
   end

   assign cmd_id    = cmd_write ? aw_id_q : ar_id_q;
   assign cmd_addr  = cmd_write ? aw_addr_q : ar_addr_q;
   assign cmd_size  = cmd_write ? aw_size_q : ar_size_q;
   assign cmd_wdata = w_data_q;
   assign cmd_strb  = w_strb_q;

endmodule

`default_nettype wire

// ==== hdl/dma_ctrl_top.sv ====
//******************************
// DCCM-only DMA slave, no rlast
// Memory reads return by tag
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_top #(
   parameter  int             DEPTH     = 4,
   parameter  int             ID_W      = 4,
   parameter  dma_pkg::addr_t DCCM_BASE = 32'hf004_0000,
   parameter  dma_pkg::addr_t DCCM_SIZE = 32'h0001_0000,
   localparam int             TAG_W     = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             reset,
   // Write address and data
   input  logic             awvalid,
   output logic             awready,
   input  logic [ID_W-1:0]  awid,
   input  dma_pkg::addr_t   awaddr,
   input  logic [2:0]       awsize,
   input  logic             wvalid,
   output logic             wready,
   input  dma_pkg::data_t   wdata,
   input  dma_pkg::strb_t   wstrb,
   output logic             bvalid,
   input  logic             bready,
   output dma_pkg::resp_e   bresp,
   output logic [ID_W-1:0]  bid,
   // Read address and data
   input  logic             arvalid,
   output logic             arready,
   input  logic [ID_W-1:0]  arid,
   input  dma_pkg::addr_t   araddr,
   input  logic [2:0]       arsize,
   output logic             rvalid,
   input  logic             rready,
   output logic [ID_W-1:0]  rid,
   output dma_pkg::data_t   rdata,
   output dma_pkg::resp_e   rresp,
   // DCCM port
   output logic             dccm_req,
   input  logic             dccm_ready,
   output logic [TAG_W-1:0] mem_tag,
   output dma_pkg::addr_t   mem_addr,
   output dma_pkg::size_e   mem_size,
   output logic             mem_write,
   output dma_pkg::data_t   mem_wdata,
   input  logic             dccm_rvalid,
   input  logic [TAG_W-1:0] dccm_rtag,
   input  dma_pkg::data_t   dccm_rdata,
   input  logic             dccm_ecc_error,
   input  logic [2:0]       qos_thresh,
   output logic             dccm_stall
);
   import dma_pkg::*;

   logic             cmd_valid, cmd_ready, cmd_write, load;
   logic [ID_W-1:0]  cmd_id, rsp_id;
   addr_t            cmd_addr, head_addr;
   size_e            cmd_size, head_size;
   data_t            cmd_wdata, rsp_data;
   strb_t            cmd_strb, head_strb;
   logic [TAG_W-1:0] wr_ptr, rd_ptr, rsp_ptr;
   logic             head_write, range_error, align_error, mem_req;
   logic             rsp_valid, rsp_ready, rsp_write;
   resp_e            rsp_code;

   assign load = cmd_valid & cmd_ready;

   dma_bus_ingress #(.ID_W(ID_W)) u_ingress (
      .clk, .reset,
      .awvalid, .awready, .awid, .awaddr, .awsize,
      .wvalid, .wready, .wdata, .wstrb,
      .arvalid, .arready, .arid, .araddr, .arsize,
      .cmd_valid, .cmd_ready, .cmd_write, .cmd_id,
      .cmd_addr, .cmd_size, .cmd_wdata, .cmd_strb
   );

   dma_entry_ctrl #(.DEPTH(DEPTH)) u_entry_ctrl (
      .clk, .reset, .cmd_valid, .cmd_ready, .cmd_write,
      .check_error (range_error | align_error),
      .dccm_ready, .dccm_rvalid, .dccm_rtag, .rsp_ready,
      .wr_ptr, .rd_ptr, .rsp_ptr, .mem_req, .dccm_req, .rsp_valid
   );

   dma_nack_timer u_nack_timer (
      .clk, .reset, .mem_req, .dccm_req, .qos_thresh, .dccm_stall
   );

   dma_access_check #(.DCCM_BASE(DCCM_BASE), .DCCM_SIZE(DCCM_SIZE)) u_access_check (
      .head_addr, .head_size, .head_strb, .head_write,
      .range_error, .align_error, .mem_addr, .mem_size
   );

   dma_entry_store #(.DEPTH(DEPTH), .ID_W(ID_W)) u_entry_store (
      .clk, .reset,
      .cmd_write, .cmd_id, .cmd_addr, .cmd_size, .cmd_wdata, .cmd_strb,
      .wr_ptr, .rd_ptr, .rsp_ptr, .load,
      .dccm_rvalid, .dccm_rtag, .dccm_rdata, .dccm_ecc_error,
      .range_error, .align_error,
      .head_addr, .head_size, .head_strb, .head_write,
      .head_wdata  (mem_wdata),
      .rsp_id, .rsp_write, .rsp_data, .rsp_code
   );

   assign mem_tag   = rd_ptr;
   assign mem_write = head_write;

   //******************************
   // AXI responses from the oldest entry
   //******************************
   assign rsp_ready = rsp_write ? bready : rready;

   assign bvalid = rsp_valid & rsp_write;
   assign bresp  = rsp_code;
   assign bid    = rsp_id;

   assign rvalid = rsp_valid & ~rsp_write;
   assign rresp  = rsp_code;
   assign rid    = rsp_id;
   assign rdata  = rsp_data;   // Address on a failed access

endmodule

`default_nettype wire

// ==== hdl/dma_entry_ctrl.sv ====
//******************************
// DEPTH must be a power of two, 2 or more
// Responses leave in entry order
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_entry_ctrl #(
   parameter  int DEPTH = 4,
   localparam int TAG_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  logic             cmd_write,
   input  logic             check_error,
   input  logic             dccm_ready,
   input  logic             dccm_rvalid,
   input  logic [TAG_W-1:0] dccm_rtag,
   input  logic             rsp_ready,
   output logic [TAG_W-1:0] wr_ptr,
   output logic [TAG_W-1:0] rd_ptr,
   output logic [TAG_W-1:0] rsp_ptr,
   output logic             mem_req,
   output logic             dccm_req,
   output logic             rsp_valid
);
   import dma_pkg::*;

   entry_state_e     state [DEPTH];
   logic [DEPTH-1:0] is_write;
   logic             load, head_queued, issue, rsp_done;

   // Entries fill in order, so a busy slot at wr_ptr means full
   assign cmd_ready   = (state[wr_ptr] == st_idle);
   assign load        = cmd_valid & cmd_ready;
   assign head_queued = (state[rd_ptr] == st_queued);
   assign mem_req     = head_queued & ~check_error;
   assign dccm_req    = mem_req & dccm_ready;
   assign issue       = dccm_req | (head_queued & check_error);   // Errors skip the memory
   assign rsp_valid   = (state[rsp_ptr] == st_done);
   assign rsp_done    = rsp_valid & rsp_ready;

   //******************************
   // Pointers and entry states
   //******************************
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         rsp_ptr <= '0;
         for (int i = 0; i < DEPTH; i++)
            state[i] <= st_idle;
      end else begin
         if (load)
            wr_ptr <= wr_ptr + TAG_W'(1);
         if (issue)
            rd_ptr <= rd_ptr + TAG_W'(1);
         if (rsp_done)
            rsp_ptr <= rsp_ptr + TAG_W'(1);
         for (int i = 0; i < DEPTH; i++) begin
            if (load && wr_ptr == TAG_W'(i))
               state[i] <= st_queued;
            else if (issue && rd_ptr == TAG_W'(i))
               state[i] <= (check_error || is_write[i]) ? st_done : st_pending;
            else if (dccm_rvalid && dccm_rtag == TAG_W'(i) && state[i] == st_pending)
               state[i] <= st_done;   // Read data is back
            else if (rsp_done && rsp_ptr == TAG_W'(i))
               state[i] <= st_idle;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load)
         is_write[wr_ptr] <= cmd_write;
   end

endmodule

`default_nettype wire

// ==== hdl/dma_entry_store.sv ====
//******************************
// Payload per entry, codes cleared by reset
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_entry_store #(
   parameter  int DEPTH = 4,
   parameter  int ID_W  = 4,
   localparam int TAG_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             cmd_write,
   input  logic [ID_W-1:0]  cmd_id,
   input  dma_pkg::addr_t   cmd_addr,
   input  dma_pkg::size_e   cmd_size,
   input  dma_pkg::data_t   cmd_wdata,
   input  dma_pkg::strb_t   cmd_strb,
   input  logic [TAG_W-1:0] wr_ptr,
   input  logic [TAG_W-1:0] rd_ptr,
   input  logic [TAG_W-1:0] rsp_ptr,
   input  logic             load,
   input  logic             dccm_rvalid,
   input  logic [TAG_W-1:0] dccm_rtag,
   input  dma_pkg::data_t   dccm_rdata,
   input  logic             dccm_ecc_error,
   input  logic             range_error,
   input  logic             align_error,
   output dma_pkg::addr_t   head_addr,
   output dma_pkg::size_e   head_size,
   output dma_pkg::strb_t   head_strb,
   output logic             head_write,
   output dma_pkg::data_t   head_wdata,
   output logic [ID_W-1:0]  rsp_id,
   output logic             rsp_write,
   output dma_pkg::data_t   rsp_data,
   output dma_pkg::resp_e   rsp_code
);
   import dma_pkg::*;

   addr_t            addr_q [DEPTH];
   size_e            size_q [DEPTH];
   strb_t            strb_q [DEPTH];
   logic [ID_W-1:0]  id_q   [DEPTH];
   data_t            data_q [DEPTH];
   resp_e            code_q [DEPTH];
   logic [DEPTH-1:0] write_q;
   logic             head_error;

   // The check depends only on stored fields, so a repeat write at rd_ptr is harmless
   assign head_error = range_error | align_error;

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (load && wr_ptr == TAG_W'(i)) begin
            addr_q[i]  <= cmd_addr;
            size_q[i]  <= cmd_size;
            strb_q[i]  <= cmd_strb;
            id_q[i]    <= cmd_id;
            write_q[i] <= cmd_write;
            data_q[i]  <= cmd_wdata;
         end else if (dccm_rvalid && dccm_rtag == TAG_W'(i)) begin
            data_q[i] <= dccm_rdata;
         end else if (head_error && rd_ptr == TAG_W'(i)) begin
            data_q[i] <= {32'b0, addr_q[i]};   // Failing address
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (reset)
            code_q[i] <= resp_okay;
         else if (load && wr_ptr == TAG_W'(i))
            code_q[i] <= resp_okay;
         else if (dccm_rvalid && dccm_rtag == TAG_W'(i))
            code_q[i] <= dccm_ecc_error ? resp_slverr : resp_okay;
         else if (head_error && rd_ptr == TAG_W'(i))
            code_q[i] <= range_error ? resp_decerr : resp_slverr;
      end
   end

   assign head_addr  = addr_q[rd_ptr];
   assign head_size  = size_q[rd_ptr];
   assign head_strb  = strb_q[rd_ptr];
   assign head_write = write_q[rd_ptr];
   assign head_wdata = data_q[rd_ptr];

   assign rsp_id    = id_q[rsp_ptr];
   assign rsp_write = write_q[rsp_ptr];
   assign rsp_data  = data_q[rsp_ptr];
   assign rsp_code  = code_q[rsp_ptr];

endmodule

`default_nettype wire

// ==== hdl/dma_nack_timer.sv ====
//******************************
// Threshold 0 stalls on any request
//******************************
`timescale 1ns/1ps
`default_nettype none

module dma_nack_timer (
   input  logic       clk,
   input  logic       reset,
   input  logic       mem_req,
   input  logic       dccm_req,
   input  logic [2:0] qos_thresh,
   output logic       dccm_stall
);

   logic [2:0] count;   // Refused cycles of the current request

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (mem_req) begin
         if (dccm_req)
            count <= '0;
         else if (count < qos_thresh)
            count <= count + 3'd1;   // Saturates at the threshold
      end
   end

   assign dccm_stall = mem_req & (count >= qos_thresh);

endmodule

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
//******************************
// Types shared by the DMA slave controller
// Bus data is 64 bits wide with byte strobes
//******************************
`default_nettype none

package dma_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;

   // Bytes per beat are 2**size
   typedef enum logic [2:0] {
      sz_byte  = 3'd0,
      sz_half  = 3'd1,
      sz_word  = 3'd2,
      sz_dword = 3'd3
   } size_e;

   typedef enum logic [1:0] {
      resp_okay   = 2'd0,
      resp_slverr = 2'd2,
      resp_decerr = 2'd3
   } resp_e;

   typedef enum logic [1:0] {
      st_idle,
      st_queued,   // Waiting for the memory
      st_pending,  // Read issued, data not back yet
      st_done
   } entry_state_e;

endpackage

`default_nettype wire

// ==== list.f ====
hdl/dma_pkg.sv
hdl/dma_bus_ingress.sv
hdl/dma_entry_ctrl.sv
hdl/dma_nack_timer.sv
hdl/dma_access_check.sv
hdl/dma_entry_store.sv
hdl/dma_ctrl_top.sv
bench/dma_mem_model.sv
bench/dma_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dma_ctrl_tb -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vdma_ctrl_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with an error status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
   exit 0
fi
exit 1
